/* design/noc_consts.svh */
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

`define NUM_PORTS 5             // local plus four mesh neighbours.
`define LEN_W 12                // packet length in flits.
`define PAYLOAD_W 16
`define KIND_W 3
`define PORT_IDX_W 3

// a head flit carries the packet length
`define FLIT_HEAD_CODE 3'b001

`endif

/* design/nocFlitPkg.sv */
`include "noc_consts.svh"

package nocFlitPkg;

  typedef enum logic [`KIND_W-1:0] {
    FLIT_IDLE = 3'b000,
    FLIT_HEAD = `FLIT_HEAD_CODE,   // length field is valid.
    FLIT_BODY = 3'b010,
    FLIT_TAIL = 3'b011
  } flitKind_e;

  typedef enum logic [`PORT_IDX_W-1:0] {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portIdx_e;

  // one input port, 32 bits
  typedef struct packed {
    logic                  req;
    flitKind_e             kind;
    logic [`LEN_W-1:0]     length;
    logic [`PAYLOAD_W-1:0] payload;
  } portIn_t;

  typedef struct packed {
    logic                  valid;
    flitKind_e             kind;
    portIdx_e              srcPort;   // port that held the grant.
    logic [`PAYLOAD_W-1:0] payload;
  } outFlit_t;

endpackage

/* design/arbPkg.sv */
`include "noc_consts.svh"

package arbPkg;

  import nocFlitPkg::*;

  // one-hot, idle in bit 0 and port p in bit p+1
  typedef enum logic [`NUM_PORTS:0] {
    GS_IDLE = 6'b000001,
    GS_L    = 6'b000010,
    GS_N    = 6'b000100,
    GS_E    = 6'b001000,
    GS_W    = 6'b010000,
    GS_S    = 6'b100000
  } grantState_e;

  // returns 1 when the state names a port.
  function automatic logic grantToPort(
    input  grantState_e g,
    output portIdx_e    port
  );
    logic hit;
    hit = 1'b1;
    port = PORT_L;
    case (g)
      GS_L: port = PORT_L;
      GS_N: port = PORT_N;
      GS_E: port = PORT_E;
      GS_W: port = PORT_W;
      GS_S: port = PORT_S;
      default: hit = 1'b0;   // idle or a broken encoding.
    endcase
    return hit;
  endfunction

  function automatic grantState_e portToGrant(input int idx);
    return grantState_e'((`NUM_PORTS + 1)'(2) << idx);
  endfunction

endpackage

/* design/portTimer.sv */
`include "noc_consts.svh"

module portTimer import nocFlitPkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  flitKind_e         kind,
  input  logic [`LEN_W-1:0] length,
  input  logic              runTimer,
  output logic              timesUp
);

  logic [`LEN_W-1:0] holdLimit;
  logic [`LEN_W-1:0] holdCount;

  // limit follows the most recent head flit on this port.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLimit <= '0;
    end
    else if (kind == FLIT_HEAD)
    begin
      holdLimit <= length;
    end
  end

  // counts cycles of an active hold, cleared otherwise.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdCount <= '0;
    end
    else if (runTimer)
    begin
      holdCount <= holdCount + 1'b1;
    end
    else
    begin
      holdCount <= '0;
    end
  end

  assign timesUp = (holdCount == holdLimit);   // seen by the arbiter in the same cycle.

endmodule

/* design/switchArbiter.sv */
`include "noc_consts.svh"

module switchArbiter import nocFlitPkg::*, arbPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  portIn_t     inPorts [`NUM_PORTS],
  output grantState_e grant
);

  grantState_e state;
  grantState_e nextState;

  logic [`NUM_PORTS-1:0] reqs;
  logic [`NUM_PORTS-1:0] runTimer;
  logic [`NUM_PORTS-1:0] timesUp;

  portIdx_e holdPort;
  logic     holdValid;

  // first requester among span ports, starting at port first and wrapping.
  function automatic grantState_e scanReq(
    input logic [`NUM_PORTS-1:0] reqVec,
    input int                    first,
    input int                    span
  );
    grantState_e pick;
    int          idx;
    pick = GS_IDLE;
    // walk backwards so the earliest requester wins.
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (first + k) % `NUM_PORTS;
      if (k < span && reqVec[idx])
      begin
        pick = portToGrant(idx);
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genPort
    assign reqs[p] = inPorts[p].req;

    portTimer portTimer0 (
      .clk      (clk),
      .rst      (rst),
      .kind     (inPorts[p].kind),
      .length   (inPorts[p].length),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= GS_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    holdValid = grantToPort(state, holdPort);
  end

  always_comb
  begin
    runTimer = '0;
    nextState = GS_IDLE;
    if (state == GS_IDLE)
    begin
      nextState = scanReq(reqs, 0, `NUM_PORTS);   // fixed priority, L first.
    end
    else if (!holdValid)
    begin
      nextState = GS_IDLE;   // recover from an illegal encoding.
    end
    else if (reqs[holdPort] && !timesUp[holdPort])
    begin
      runTimer[holdPort] = 1'b1;
      nextState = state;
    end
    else
    begin
      // rotate: start after the holder and skip it.
      nextState = scanReq(reqs, int'(holdPort) + 1, `NUM_PORTS - 1);
    end
  end

  assign grant = state;

endmodule

/* design/outputMux.sv */
`include "noc_consts.svh"

module outputMux import nocFlitPkg::*, arbPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  portIn_t     inPorts [`NUM_PORTS],
  input  grantState_e grant,
  output outFlit_t    outFlit
);

  portIdx_e selPort;
  logic     selValid;
  portIn_t  selFlit;

  always_comb
  begin
    selValid = grantToPort(grant, selPort);
  end

  assign selFlit = inPorts[selPort];

  // only valid is cleared, the other fields keep the last forwarded flit.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit.valid <= 1'b0;
    end
    else if (selValid && selFlit.req)
    begin
      outFlit.valid   <= 1'b1;
      outFlit.kind    <= selFlit.kind;
      outFlit.srcPort <= selPort;
      outFlit.payload <= selFlit.payload;
    end
    else
    begin
      outFlit.valid <= 1'b0;   // idle or granted port went quiet.
    end
  end

endmodule

/* design/outputPortTop.sv */
`include "noc_consts.svh"

module outputPortTop import nocFlitPkg::*, arbPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  portIn_t     inPorts [`NUM_PORTS],
  output grantState_e grant,
  output outFlit_t    outFlit
);

  switchArbiter arbiter0 (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant)
  );

  // forwards the flit one cycle behind the grant.
  outputMux mux0 (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant),
    .outFlit (outFlit)
  );

endmodule

/* bench/outputPortTb.sv */
`include "noc_consts.svh"

module outputPortTb import nocFlitPkg::*, arbPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxVectors = 1000;
  localparam int NumCols = 5 * 4 + 5;

  logic        clk;
  logic        rst;
  portIn_t     inPorts [`NUM_PORTS];
  grantState_e grant;
  outFlit_t    outFlit;

  outputPortTop dut0 (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant),
    .outFlit (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  task automatic reportMismatch(input string sig, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("[ERROR] %s expected 0x%h actual 0x%h", sig, expVal, actVal);
    $display("ERRORS FOUND");
    $fatal(1, "value mismatch");
  endtask

  task automatic checkGrant(input grantState_e expGrant, input grantState_e actGrant);
    if (actGrant !== expGrant)
    begin
      reportMismatch("grant", 32'(expGrant), 32'(actGrant));
    end
  endtask

  // fields other than valid are only defined once a flit was forwarded.
  task automatic checkOutFlit(input outFlit_t expFlit, input outFlit_t actFlit);
    if (actFlit.valid !== expFlit.valid)
    begin
      reportMismatch("outFlit.valid", 32'(expFlit.valid), 32'(actFlit.valid));
    end
    if (expFlit.valid)
    begin
      if (actFlit.kind !== expFlit.kind)
      begin
        reportMismatch("outFlit.kind", 32'(expFlit.kind), 32'(actFlit.kind));
      end
      if (actFlit.srcPort !== expFlit.srcPort)
      begin
        reportMismatch("outFlit.srcPort", 32'(expFlit.srcPort), 32'(actFlit.srcPort));
      end
      if (actFlit.payload !== expFlit.payload)
      begin
        reportMismatch("outFlit.payload", 32'(expFlit.payload), 32'(actFlit.payload));
      end
    end
  endtask

  function automatic portIn_t quietPort();
    portIn_t p;
    p.req = 1'b0;
    p.kind = FLIT_IDLE;
    p.length = '0;
    p.payload = '0;
    return p;
  endfunction

  initial
  begin
    int          fd;
    int          nCols;
    int          vecCount;
    bit          havePending;
    string       line;
    logic [31:0] fReq [`NUM_PORTS];
    logic [31:0] fKind [`NUM_PORTS];
    logic [31:0] fLen [`NUM_PORTS];
    logic [31:0] fPay [`NUM_PORTS];
    logic [31:0] eGrant;
    logic [31:0] eValid;
    logic [31:0] eKind;
    logic [31:0] eSrc;
    logic [31:0] ePay;
    portIn_t     vecIn [`NUM_PORTS];
    grantState_e pendGrant;
    outFlit_t    pendFlit;
    outFlit_t    idleFlit;

    havePending = 1'b0;
    vecCount = 0;
    idleFlit = '0;
    pendGrant = GS_IDLE;
    pendFlit = '0;

    // requests on L and S must be ignored while in reset.
    rst = 1'b1;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inPorts[p] = quietPort();
    end
    inPorts[PORT_L].req = 1'b1;
    inPorts[PORT_S].req = 1'b1;

    for (int c = 0; c < 3; c++)
    begin
      @(posedge clk);
      if (c == 2)
      begin
        rst <= 1'b0;
        for (int p = 0; p < `NUM_PORTS; p++)
        begin
          inPorts[p] <= quietPort();
        end
      end
      @(negedge clk);
      checkGrant(GS_IDLE, grant);
      checkOutFlit(idleFlit, outFlit);
    end

    fd = $fopen("bench/arb_vectors.txt", "r");
    if (fd == 0)
    begin
      abortRun("could not open the vectors file bench/arb_vectors.txt");
    end

    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.getc(0) == 8'h23)
      begin
        continue;   // comment or blank line.
      end
      nCols = $sscanf(line,
        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        fReq[0], fKind[0], fLen[0], fPay[0], fReq[1], fKind[1], fLen[1], fPay[1],
        fReq[2], fKind[2], fLen[2], fPay[2], fReq[3], fKind[3], fLen[3], fPay[3],
        fReq[4], fKind[4], fLen[4], fPay[4], eGrant, eValid, eKind, eSrc, ePay);
      if (nCols != NumCols)
      begin
        abortRun("a line of the vectors file has the wrong number of columns");
      end
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        vecIn[p].req = fReq[p][0];
        vecIn[p].kind = flitKind_e'(fKind[p][`KIND_W-1:0]);
        vecIn[p].length = fLen[p][`LEN_W-1:0];
        vecIn[p].payload = fPay[p][`PAYLOAD_W-1:0];
      end

      @(posedge clk);
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        inPorts[p] <= vecIn[p];
      end
      @(negedge clk);
      if (havePending)
      begin
        checkGrant(pendGrant, grant);   // response to the previous line.
        checkOutFlit(pendFlit, outFlit);
      end

      pendGrant = grantState_e'(eGrant[`NUM_PORTS:0]);
      pendFlit.valid = eValid[0];
      pendFlit.kind = flitKind_e'(eKind[`KIND_W-1:0]);
      pendFlit.srcPort = portIdx_e'(eSrc[`PORT_IDX_W-1:0]);
      pendFlit.payload = ePay[`PAYLOAD_W-1:0];
      havePending = 1'b1;

      vecCount++;
      if (vecCount > MaxVectors)
      begin
        abortRun("vector loop ran too many cycles without reaching the end of the file");
      end
    end
    $fclose(fd);

    if (!havePending)
    begin
      abortRun("the vectors file holds no vectors");
    end

    // last line's response.
    @(posedge clk);
    @(negedge clk);
    checkGrant(pendGrant, grant);
    checkOutFlit(pendFlit, outFlit);

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* bench/arb_vectors.txt */
# per port in order L N E W S: req kind length payload; then grant valid kind srcPort payload
# the expected columns are the outputs one clock after this line's inputs are applied
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000
1 1 002 a100 1 1 001 b100 0 0 000 0000 0 0 000 0000 1 1 000 f100 02 0 0 0 0000
1 2 000 a101 1 2 000 b101 0 0 000 0000 0 0 000 0000 1 2 000 f101 02 1 2 0 a101
1 2 000 a102 1 2 000 b101 0 0 000 0000 0 0 000 0000 1 2 000 f101 02 1 2 0 a102
1 3 000 a103 1 2 000 b101 0 0 000 0000 0 0 000 0000 1 2 000 f101 04 1 3 0 a103
0 0 000 0000 1 2 000 b102 0 0 000 0000 0 0 000 0000 1 2 000 f102 04 1 2 1 b102
0 0 000 0000 1 3 000 b103 0 0 000 0000 0 0 000 0000 1 2 000 f102 20 1 3 1 b103
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 1 2 000 f103 01 1 2 4 f103
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 1 3 000 f104 20 0 0 0 0000
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 1 3 000 f105 01 1 3 4 f105
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000
0 0 000 0000 0 0 000 0000 1 1 003 c200 1 1 001 d200 0 0 000 0000 08 0 0 0 0000
0 0 000 0000 0 0 000 0000 1 2 000 c201 1 2 000 d201 0 0 000 0000 08 1 2 2 c201
0 0 000 0000 0 0 000 0000 0 0 000 c202 1 2 000 d201 0 0 000 0000 10 0 0 0 0000
0 0 000 0000 0 0 000 0000 0 0 000 0000 1 2 000 d202 0 0 000 0000 10 1 2 3 d202
0 0 000 0000 0 0 000 0000 1 1 001 c203 1 2 000 d203 0 0 000 0000 08 1 2 3 d203
0 0 000 0000 0 0 000 0000 1 2 000 c204 0 0 000 0000 0 0 000 0000 08 1 2 2 c204
0 0 000 0000 0 0 000 0000 1 2 000 c205 0 0 000 0000 0 0 000 0000 01 1 2 2 c205
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000
0 0 000 0000 1 1 000 b300 0 0 000 0000 1 1 002 d300 1 1 001 f300 04 0 0 0 0000
0 0 000 0000 1 2 000 b301 0 0 000 0000 1 2 000 d301 1 2 000 f301 10 1 2 1 b301
1 1 000 a300 1 2 000 b302 0 0 000 0000 1 2 000 d302 1 2 000 f302 10 1 2 3 d302
1 2 000 a301 1 2 000 b303 0 0 000 0000 1 2 000 d303 1 2 000 f303 10 1 2 3 d303
1 2 000 a302 1 2 000 b304 0 0 000 0000 1 3 000 d304 1 2 000 f304 20 1 3 3 d304
1 2 000 a303 1 2 000 b305 0 0 000 0000 0 0 000 0000 1 2 000 f305 20 1 2 4 f305
1 2 000 a304 1 2 000 b306 0 0 000 0000 0 0 000 0000 1 3 000 f306 02 1 3 4 f306
1 2 000 a305 1 2 000 b307 0 0 000 0000 0 0 000 0000 0 0 000 0000 04 1 2 0 a305
1 2 000 a306 1 3 000 b308 0 0 000 0000 0 0 000 0000 0 0 000 0000 02 1 3 1 b308
1 3 000 a307 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 1 3 0 a307
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000
0 0 000 0000 0 0 000 0000 0 1 000 c400 0 0 000 0000 1 1 005 f400 20 0 0 0 0000
0 0 000 0000 0 0 000 0000 1 2 000 c401 0 0 000 0000 1 2 000 f401 20 1 2 4 f401
0 0 000 0000 0 0 000 0000 1 2 000 c402 0 0 000 0000 1 2 000 f402 20 1 2 4 f402
0 0 000 0000 0 0 000 0000 1 2 000 c402 0 0 000 0000 1 2 000 f403 20 1 2 4 f403
0 0 000 0000 0 0 000 0000 1 2 000 c403 0 0 000 0000 0 0 000 f404 08 0 0 0 0000
0 0 000 0000 0 0 000 0000 1 2 000 c404 0 0 000 0000 0 0 000 0000 01 1 2 2 c404
0 0 000 0000 0 0 000 0000 1 3 000 c405 0 0 000 0000 0 0 000 0000 08 0 0 0 0000
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000
1 1 000 a500 1 1 000 b500 1 1 000 c500 1 1 000 d500 1 1 000 f500 02 0 0 0 0000
1 2 000 a501 1 2 000 b501 1 2 000 c501 1 2 000 d501 1 2 000 f501 04 1 2 0 a501
1 2 000 a502 1 2 000 b502 1 2 000 c502 1 2 000 d502 1 2 000 f502 08 1 2 1 b502
1 2 000 a503 1 2 000 b503 1 2 000 c503 1 2 000 d503 1 2 000 f503 10 1 2 2 c503
1 2 000 a504 1 2 000 b504 1 2 000 c504 1 2 000 d504 1 2 000 f504 20 1 2 3 d504
1 3 000 a505 1 3 000 b505 1 3 000 c505 1 3 000 d505 1 3 000 f505 02 1 3 4 f505
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000
0 0 000 0000 0 0 000 0000 0 0 000 0000 1 1 003 d600 0 0 000 0000 10 0 0 0 0000
1 1 001 a600 0 0 000 0000 0 0 000 0000 1 2 000 d601 0 0 000 0000 10 1 2 3 d601
1 2 000 a601 0 0 000 0000 0 0 000 0000 1 2 000 d602 0 0 000 0000 10 1 2 3 d602
1 2 000 a602 0 0 000 0000 0 0 000 0000 1 2 000 d603 0 0 000 0000 10 1 2 3 d603
1 2 000 a603 0 0 000 0000 0 0 000 0000 1 3 000 d604 0 0 000 0000 02 1 3 3 d604
1 2 000 a604 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 02 1 2 0 a604
1 3 000 a605 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 1 3 0 a605
0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 0 0 000 0000 01 0 0 0 0000

/* filelist.f */
+incdir+design
design/nocFlitPkg.sv
design/arbPkg.sv
design/portTimer.sv
design/switchArbiter.sv
design/outputMux.sv
design/outputPortTop.sv
bench/outputPortTb.sv

/* Makefile */
SIM := obj_dir/VoutputPortTb
SRCS := $(shell grep -v '^+' filelist.f) design/noc_consts.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): filelist.f $(SRCS)
	verilator --binary --timescale 1ns/1ps -f filelist.f --top-module outputPortTb \
		-o VoutputPortTb

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
